/* decode_stage.sv */
`timescale 1ns/1ns
`include "lc3b_config.svh"

module decode_stage import lc3b_types::*; (
	input logic clk,
	input logic arst_n,
	pipe_ctrl_if.decode ctrl,
	input if_id_t if_id,
	input logic wb_we,
	input lc3b_reg wb_dest,
	input lc3b_word wb_data,
	output id_ex_t id_ex
);

lc3b_word regfile [`LC3B_NUM_REGS];
lc3b_word instr;
lc3b_opcode opcode;
lc3b_reg sr1;
lc3b_reg sr2;
logic use_sr1;
logic use_sr2;
id_ex_t dec;

assign instr = if_id.instr;
assign opcode = lc3b_opcode'(instr[15:12]);
assign sr1 = instr[8:6];
assign sr2 = (opcode == op_str) ? instr[11:9] : instr[2:0]; // Store data comes in on sr2.

always_comb begin
	dec = '0;
	use_sr1 = 1'b0;
	use_sr2 = 1'b0;
	dec.opcode = opcode;
	dec.sr1 = sr1;
	dec.sr2 = sr2;
	dec.dest = instr[11:9];
	dec.nzp_mask = instr[11:9];
	dec.pc_plus2 = if_id.pc_plus2;
	dec.sr1_data = (wb_we && wb_dest == sr1) ? wb_data : regfile[sr1]; // Write-through.
	dec.sr2_data = (wb_we && wb_dest == sr2) ? wb_data : regfile[sr2];
	case (opcode)
		op_add, op_and: begin
			dec.valid = if_id.valid;
			dec.aluop = (opcode == op_add) ? alu_add : alu_and;
			dec.use_imm = instr[5];
			dec.imm = {{11{instr[4]}}, instr[4:0]};
			dec.reg_we = 1'b1;
			use_sr1 = 1'b1;
			use_sr2 = !instr[5];
		end
		op_not: begin
			dec.valid = if_id.valid;
			dec.aluop = alu_not;
			dec.reg_we = 1'b1;
			use_sr1 = 1'b1;
		end
		op_ldr, op_str: begin
			dec.valid = if_id.valid;
			dec.aluop = alu_add;
			dec.use_imm = 1'b1;
			dec.imm = {{10{instr[5]}}, instr[5:0]};
			dec.reg_we = (opcode == op_ldr);
			dec.mem_read = (opcode == op_ldr);
			dec.mem_write = (opcode == op_str);
			use_sr1 = 1'b1;
			use_sr2 = (opcode == op_str);
		end
		op_br: begin
			dec.valid = if_id.valid;
			dec.imm = {{7{instr[8]}}, instr[8:0]};
		end
		default: dec.valid = 1'b0; // Unsupported opcodes go down as bubbles.
	endcase
end

// A load one stage ahead cannot forward in time.
assign ctrl.hold = if_id.valid && id_ex.valid && id_ex.mem_read &&
	((use_sr1 && id_ex.dest == sr1) || (use_sr2 && id_ex.dest == sr2));

always_ff @(posedge clk) begin
	if (wb_we) begin
		regfile[wb_dest] <= wb_data;
	end
end

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		id_ex <= '0;
	end else if (ctrl.advance) begin
		if (ctrl.redirect || ctrl.hold) begin
			id_ex <= '0;
		end else begin
			id_ex <= dec;
		end
	end
end

endmodule : decode_stage

/* execute_stage.sv */
`timescale 1ns/1ns

module execute_stage import lc3b_types::*; (
	input logic clk,
	input logic arst_n,
	pipe_ctrl_if.execute ctrl,
	input id_ex_t id_ex,
	input logic wb_we,
	input lc3b_reg wb_dest,
	input lc3b_word wb_data,
	output ex_mem_t ex_mem
);

lc3b_word src1;
lc3b_word src2;
lc3b_word opb;
lc3b_word alu_out;
lc3b_word br_target;

// Newest producer wins. A load in EX/MEM has no data yet.
function automatic lc3b_word pick_src(
	input lc3b_reg sr,
	input lc3b_word decoded,
	input ex_mem_t older,
	input logic wr_en,
	input lc3b_reg wr_dest,
	input lc3b_word wr_data
);
	if (older.valid && older.reg_we && !older.mem_read && older.dest == sr) begin
		return older.alu_result;
	end
	if (wr_en && wr_dest == sr) begin
		return wr_data;
	end
	return decoded;
endfunction

assign src1 = pick_src(id_ex.sr1, id_ex.sr1_data, ex_mem, wb_we, wb_dest, wb_data);
assign src2 = pick_src(id_ex.sr2, id_ex.sr2_data, ex_mem, wb_we, wb_dest, wb_data);

assign opb = (id_ex.mem_read || id_ex.mem_write) ? {id_ex.imm[14:0], 1'b0} :
	id_ex.use_imm ? id_ex.imm : src2;

always_comb begin
	case (id_ex.aluop)
		alu_add: alu_out = src1 + opb;
		alu_and: alu_out = src1 & opb;
		alu_not: alu_out = ~src1;
		default: alu_out = src1;
	endcase
end

assign br_target = id_ex.pc_plus2 + {id_ex.imm[14:0], 1'b0}; // offset9 in words.

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		ex_mem <= '0;
	end else if (ctrl.advance) begin
		if (ctrl.redirect) begin
			ex_mem <= '0;
		end else begin
			ex_mem <= '{valid: id_ex.valid, opcode: id_ex.opcode, dest: id_ex.dest,
				reg_we: id_ex.reg_we, mem_read: id_ex.mem_read, mem_write: id_ex.mem_write,
				alu_result: alu_out, store_data: src2, br_target: br_target,
				nzp_mask: id_ex.nzp_mask};
		end
	end
end

endmodule : execute_stage

/* fetch_stage.sv */
`timescale 1ns/1ns
`include "lc3b_config.svh"

module fetch_stage import lc3b_types::*; (
	input logic clk,
	input logic arst_n,
	pipe_ctrl_if.fetch ctrl,
	input lc3b_word imem_rdata,
	input logic imem_resp,
	output lc3b_word imem_address,
	output logic imem_cyc,
	output logic imem_stb,
	output if_id_t if_id
);

lc3b_word pc;
lc3b_word pc_plus2;
logic req;

assign pc_plus2 = pc + 16'd2;
assign imem_address = pc;
assign imem_cyc = req;
assign imem_stb = req;

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		req <= 1'b0;
	end else begin
		// A response the frozen pipeline cannot take ends the access, then it is retried.
		req <= !(imem_resp && !ctrl.advance);
	end
end

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		pc <= `LC3B_RESET_PC;
		if_id <= '0;
	end else if (ctrl.advance) begin
		if (ctrl.redirect) begin
			pc <= ctrl.redirect_pc;
			if_id <= '0; // Drop the word behind the branch.
		end else if (!ctrl.hold) begin
			pc <= pc_plus2;
			if_id <= '{valid: 1'b1, pc_plus2: pc_plus2, instr: imem_rdata};
		end
		// On hold the dependent word stays in IF/ID and pc is fetched again.
	end
end

endmodule : fetch_stage

/* files.f */
+incdir+.
lc3b_types.sv
pipe_ctrl_if.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
lc3b_pipeline.sv
lc3b_pipeline_assert.sv
tb_lc3b_pipeline.sv

/* lc3b_config.svh */
`ifndef LC3B_CONFIG_SVH
`define LC3B_CONFIG_SVH

// Address of the first instruction after reset.
`define LC3B_RESET_PC 16'h0000

// General purpose registers R0 to R7.
`define LC3B_NUM_REGS 8

`endif

/* lc3b_pipeline.sv */
`timescale 1ns/1ns

module lc3b_pipeline import lc3b_types::*; (
	input logic clk,
	input logic arst_n,

	input lc3b_word imem_rdata,
	input logic imem_resp,
	output lc3b_word imem_address,
	output logic imem_cyc,
	output logic imem_stb,

	input lc3b_word dmem_rdata,
	input logic dmem_resp,
	output lc3b_word dmem_address,
	output lc3b_word dmem_wdata,
	output logic dmem_write,
	output logic dmem_cyc,
	output logic dmem_stb
);

if_id_t if_id;
id_ex_t id_ex;
ex_mem_t ex_mem;
logic wb_we;
lc3b_reg wb_dest;
lc3b_word wb_data;

pipe_ctrl_if u_ctrl ();

fetch_stage u_fetch (
	.clk(clk),
	.arst_n(arst_n),
	.ctrl(u_ctrl),
	.imem_rdata(imem_rdata),
	.imem_resp(imem_resp),
	.imem_address(imem_address),
	.imem_cyc(imem_cyc),
	.imem_stb(imem_stb),
	.if_id(if_id)
);

decode_stage u_decode (
	.clk(clk),
	.arst_n(arst_n),
	.ctrl(u_ctrl),
	.if_id(if_id),
	.wb_we(wb_we),
	.wb_dest(wb_dest),
	.wb_data(wb_data),
	.id_ex(id_ex)
);

execute_stage u_execute (
	.clk(clk),
	.arst_n(arst_n),
	.ctrl(u_ctrl),
	.id_ex(id_ex),
	.wb_we(wb_we),
	.wb_dest(wb_dest),
	.wb_data(wb_data),
	.ex_mem(ex_mem)
);

memory_stage u_memory (
	.clk(clk),
	.arst_n(arst_n),
	.ctrl(u_ctrl),
	.imem_resp(imem_resp),
	.ex_mem(ex_mem),
	.dmem_rdata(dmem_rdata),
	.dmem_resp(dmem_resp),
	.dmem_address(dmem_address),
	.dmem_wdata(dmem_wdata),
	.dmem_write(dmem_write),
	.dmem_cyc(dmem_cyc),
	.dmem_stb(dmem_stb),
	.wb_we(wb_we),
	.wb_dest(wb_dest),
	.wb_data(wb_data)
);

endmodule : lc3b_pipeline

/* lc3b_pipeline_assert.sv */
`timescale 1ns/1ns

module lc3b_pipeline_assert import lc3b_types::*; (
	input logic clk,
	input logic arst_n,
	input lc3b_word imem_address,
	input logic imem_cyc,
	input logic imem_stb,
	input logic imem_resp,
	input lc3b_word dmem_address,
	input lc3b_word dmem_wdata,
	input logic dmem_write,
	input logic dmem_cyc,
	input logic dmem_stb,
	input logic dmem_resp
);

imem_stb_in_cyc: assert property (@(posedge clk) disable iff (!arst_n)
	imem_stb |-> imem_cyc) else $error("imem stb raised without cyc");

dmem_stb_in_cyc: assert property (@(posedge clk) disable iff (!arst_n)
	dmem_stb |-> dmem_cyc) else $error("dmem stb raised without cyc");

// A request without resp must be held unchanged into the next cycle.
imem_held: assert property (@(posedge clk) disable iff (!arst_n)
	(imem_stb && !imem_resp) |=> imem_stb && $stable(imem_address))
	else $error("imem request changed before resp");

dmem_held: assert property (@(posedge clk) disable iff (!arst_n)
	(dmem_stb && !dmem_resp) |=> dmem_stb && $stable(dmem_address) &&
	$stable(dmem_wdata) && $stable(dmem_write))
	else $error("dmem request changed before resp");

dmem_write_in_access: assert property (@(posedge clk) disable iff (!arst_n)
	dmem_write |-> dmem_cyc && dmem_stb) else $error("dmem write outside an access");

endmodule : lc3b_pipeline_assert

bind lc3b_pipeline lc3b_pipeline_assert u_assert (
	.clk(clk),
	.arst_n(arst_n),
	.imem_address(imem_address),
	.imem_cyc(imem_cyc),
	.imem_stb(imem_stb),
	.imem_resp(imem_resp),
	.dmem_address(dmem_address),
	.dmem_wdata(dmem_wdata),
	.dmem_write(dmem_write),
	.dmem_cyc(dmem_cyc),
	.dmem_stb(dmem_stb),
	.dmem_resp(dmem_resp)
);

/* lc3b_types.sv */
package lc3b_types;

typedef logic [15:0] lc3b_word;
typedef logic [2:0] lc3b_reg;
typedef logic [2:0] lc3b_nzp;

typedef enum logic [3:0] {
	op_br  = 4'b0000,
	op_add = 4'b0001,
	op_and = 4'b0101,
	op_ldr = 4'b0110,
	op_str = 4'b0111,
	op_not = 4'b1001
} lc3b_opcode;

typedef enum logic [1:0] {
	alu_pass,
	alu_add,
	alu_and,
	alu_not
} lc3b_aluop;

typedef struct packed {
	logic valid;
	lc3b_word pc_plus2;
	lc3b_word instr;
} if_id_t;

typedef struct packed {
	logic valid;
	lc3b_opcode opcode;
	lc3b_aluop aluop;
	logic use_imm; // Second ALU operand is imm.
	lc3b_reg sr1;
	lc3b_reg sr2; // SR field for STR.
	lc3b_reg dest;
	logic reg_we;
	logic mem_read;
	logic mem_write;
	lc3b_word sr1_data;
	lc3b_word sr2_data;
	lc3b_word imm; // imm5, offset6 or offset9, sign-extended.
	lc3b_word pc_plus2;
	lc3b_nzp nzp_mask;
} id_ex_t;

typedef struct packed {
	logic valid;
	lc3b_opcode opcode;
	lc3b_reg dest;
	logic reg_we;
	logic mem_read;
	logic mem_write;
	lc3b_word alu_result; // Also the data address for LDR and STR.
	lc3b_word store_data;
	lc3b_word br_target;
	lc3b_nzp nzp_mask;
} ex_mem_t;

typedef struct packed {
	logic valid;
	lc3b_reg dest;
	logic reg_we;
	lc3b_word result;
} mem_wb_t;

endpackage : lc3b_types

/* memory_stage.sv */
`timescale 1ns/1ns

module memory_stage import lc3b_types::*; (
	input logic clk,
	input logic arst_n,
	pipe_ctrl_if.memory ctrl,
	input logic imem_resp,
	input ex_mem_t ex_mem,
	input lc3b_word dmem_rdata,
	input logic dmem_resp,
	output lc3b_word dmem_address,
	output lc3b_word dmem_wdata,
	output logic dmem_write,
	output logic dmem_cyc,
	output logic dmem_stb,
	output logic wb_we,
	output lc3b_reg wb_dest,
	output lc3b_word wb_data
);

typedef enum logic [1:0] {st_idle, st_wait, st_done} dmem_state_t;

dmem_state_t state;
logic need_access;
logic busy;
lc3b_word load_data;
lc3b_word result;
lc3b_nzp nzp;
lc3b_nzp nzp_next;
mem_wb_t mem_wb;

assign need_access = ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write);
assign busy = (state == st_idle && need_access) || state == st_wait; // Up on entry.
assign dmem_cyc = busy;
assign dmem_stb = busy;
assign dmem_write = busy && ex_mem.mem_write;
assign dmem_address = ex_mem.alu_result;
assign dmem_wdata = ex_mem.store_data;

assign ctrl.advance = imem_resp && !busy;

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		state <= st_idle;
	end else begin
		case (state)
			st_idle: if (need_access) state <= dmem_resp ? st_done : st_wait;
			st_wait: if (dmem_resp) state <= st_done;
			st_done: if (ctrl.advance) state <= st_idle; // Wait here for the fetch side.
			default: state <= st_idle;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (busy && dmem_resp) begin
		load_data <= dmem_rdata;
	end
end

assign result = ex_mem.mem_read ? load_data : ex_mem.alu_result;
assign nzp_next = result[15] ? 3'b100 : (result == 16'h0000) ? 3'b010 : 3'b001;

assign ctrl.redirect = ex_mem.valid && ex_mem.opcode == op_br && |(ex_mem.nzp_mask & nzp);
assign ctrl.redirect_pc = ex_mem.br_target;

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		nzp <= '0;
		mem_wb <= '0;
	end else if (ctrl.advance) begin
		if (ex_mem.valid && ex_mem.reg_we) begin
			nzp <= nzp_next;
		end
		mem_wb <= '{valid: ex_mem.valid, dest: ex_mem.dest, reg_we: ex_mem.reg_we,
			result: result};
	end
end

assign wb_we = mem_wb.valid && mem_wb.reg_we;
assign wb_dest = mem_wb.dest;
assign wb_data = mem_wb.result;

endmodule : memory_stage

/* pipe_ctrl_if.sv */
`timescale 1ns/1ns

interface pipe_ctrl_if import lc3b_types::*; ();

logic advance; // All stage registers load.
logic hold; // Load-use interlock.
logic redirect; // Taken branch in the memory stage.
lc3b_word redirect_pc;

modport fetch (input advance, input hold, input redirect, input redirect_pc);

modport decode (output hold, input advance, input redirect);

modport execute (input advance, input redirect);

modport memory (output advance, output redirect, output redirect_pc);

endinterface : pipe_ctrl_if

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_lc3b_pipeline -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_lc3b_pipeline > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Errors found" sim.log; then
	exit 1
fi
exit 0

/* tb_lc3b_pipeline.sv */
`timescale 1ns/1ns
`include "lc3b_config.svh"

module tb_lc3b_pipeline import lc3b_types::*; ();

localparam int num_tests = 3;
localparam int max_len = 20;
localparam int max_stores = 4;
localparam int timeout_cycles = 2000;

logic clk;
logic arst_n;
lc3b_word imem_rdata;
logic imem_resp;
lc3b_word imem_address;
logic imem_cyc;
logic imem_stb;
lc3b_word dmem_rdata;
logic dmem_resp;
lc3b_word dmem_address;
lc3b_word dmem_wdata;
logic dmem_write;
logic dmem_cyc;
logic dmem_stb;

lc3b_word imem [64];
lc3b_word dmem [64];
lc3b_word prog [num_tests][max_len];
int prog_len [num_tests];
int exp_cnt [num_tests];
lc3b_word exp_addr [num_tests][max_stores];
lc3b_word exp_data [num_tests][max_stores];
lc3b_word st_addr_q [$]; // Stores seen on the data port in order.
lc3b_word st_data_q [$];
integer seed = 32'hba67;
int errors;
int failed_tests;
int i_wait;
int d_wait;
logic i_busy;
logic d_busy;

lc3b_pipeline u_lc3b_pipeline (
	.clk(clk),
	.arst_n(arst_n),
	.imem_rdata(imem_rdata),
	.imem_resp(imem_resp),
	.imem_address(imem_address),
	.imem_cyc(imem_cyc),
	.imem_stb(imem_stb),
	.dmem_rdata(dmem_rdata),
	.dmem_resp(dmem_resp),
	.dmem_address(dmem_address),
	.dmem_wdata(dmem_wdata),
	.dmem_write(dmem_write),
	.dmem_cyc(dmem_cyc),
	.dmem_stb(dmem_stb)
);

initial clk = 1'b0;
always #20 clk = ~clk;

// Instruction memory answers in 1 to 3 cycles.
always begin
	@(posedge clk);
	#2;
	if (!arst_n) begin
		imem_resp = 1'b0;
		i_busy = 1'b0;
	end else begin
		if (imem_resp) begin
			imem_resp = 1'b0;
			i_busy = 1'b0;
		end
		if (!i_busy && imem_cyc && imem_stb) begin
			i_busy = 1'b1;
			i_wait = $unsigned($random(seed)) % 3;
		end else if (i_busy) begin
			i_wait--;
		end
		if (i_busy && i_wait == 0) begin
			imem_resp = 1'b1;
			imem_rdata = imem[imem_address[6:1]];
		end
	end
end

// Data memory; writes are logged when answered.
always begin
	@(posedge clk);
	#2;
	if (!arst_n) begin
		dmem_resp = 1'b0;
		d_busy = 1'b0;
	end else begin
		if (dmem_resp) begin
			dmem_resp = 1'b0;
			d_busy = 1'b0;
		end
		if (!d_busy && dmem_cyc && dmem_stb) begin
			d_busy = 1'b1;
			d_wait = $unsigned($random(seed)) % 3;
		end else if (d_busy) begin
			d_wait--;
		end
		if (d_busy && d_wait == 0) begin
			dmem_resp = 1'b1;
			if (dmem_write) begin
				dmem[dmem_address[6:1]] = dmem_wdata;
				st_addr_q.push_back(dmem_address);
				st_data_q.push_back(dmem_wdata);
			end
			dmem_rdata = dmem[dmem_address[6:1]];
		end
	end
end

function automatic lc3b_word alu_i(input logic [3:0] op, input lc3b_reg dr, input lc3b_reg sr,
	input logic [4:0] imm);
	return {op, dr, sr, 1'b1, imm};
endfunction

function automatic lc3b_word alu_r(input logic [3:0] op, input lc3b_reg dr, input lc3b_reg sr1,
	input lc3b_reg sr2);
	return {op, dr, sr1, 3'b000, sr2};
endfunction

function automatic lc3b_word not_r(input lc3b_reg dr, input lc3b_reg sr);
	return {4'b1001, dr, sr, 6'b111111};
endfunction

function automatic lc3b_word mem(input logic [3:0] op, input lc3b_reg r, input lc3b_reg base,
	input logic [5:0] off);
	return {op, r, base, off};
endfunction

function automatic lc3b_word br(input lc3b_nzp cond, input logic [8:0] off);
	return {4'b0000, cond, off};
endfunction

task automatic put(input int t, input lc3b_word w);
	prog[t][prog_len[t]] = w;
	prog_len[t]++;
endtask

task automatic add_store(input int t, input lc3b_word addr, input lc3b_word data);
	exp_addr[t][exp_cnt[t]] = addr;
	exp_data[t][exp_cnt[t]] = data;
	exp_cnt[t]++;
endtask

task automatic build_tables();
	for (int t = 0; t < num_tests; t++) begin
		prog_len[t] = 0;
		exp_cnt[t] = 0;
	end
	// Dependent ALU chain.
	put(0, alu_i(op_and, 3'd1, 3'd1, 5'd0));
	put(0, alu_i(op_and, 3'd0, 3'd0, 5'd0));
	put(0, alu_i(op_add, 3'd1, 3'd1, 5'd7));
	put(0, alu_i(op_add, 3'd2, 3'd1, 5'h1d)); // R2 = 7 - 3.
	put(0, alu_r(op_add, 3'd3, 3'd1, 3'd2));
	put(0, alu_i(op_and, 3'd4, 3'd3, 5'd6));
	put(0, not_r(3'd5, 3'd4));
	put(0, alu_r(op_and, 3'd6, 3'd5, 3'd3));
	put(0, mem(op_str, 3'd6, 3'd0, 6'd10));
	put(0, mem(op_str, 3'd3, 3'd0, 6'd8));
	put(0, mem(op_str, 3'd5, 3'd0, 6'd9));
	put(0, br(3'b111, 9'h1ff));
	add_store(0, 16'h0014, 16'h0009);
	add_store(0, 16'h0010, 16'h000b);
	add_store(0, 16'h0012, 16'hfffd);
	// Load followed directly by its use.
	put(1, alu_i(op_and, 3'd0, 3'd0, 5'd0));
	put(1, alu_i(op_and, 3'd1, 3'd1, 5'd0));
	put(1, alu_i(op_add, 3'd1, 3'd1, 5'd12));
	put(1, mem(op_str, 3'd1, 3'd0, 6'd16));
	put(1, mem(op_ldr, 3'd2, 3'd0, 6'd16));
	put(1, alu_r(op_add, 3'd3, 3'd2, 3'd1));
	put(1, mem(op_str, 3'd3, 3'd0, 6'd17));
	put(1, mem(op_ldr, 3'd4, 3'd0, 6'd17));
	put(1, mem(op_str, 3'd4, 3'd0, 6'd18));
	put(1, br(3'b111, 9'h1ff));
	add_store(1, 16'h0020, 16'h000c);
	add_store(1, 16'h0022, 16'h0018);
	add_store(1, 16'h0024, 16'h0018);
	// Branches on ALU and load codes; stores in squashed slots must not show.
	put(2, alu_i(op_and, 3'd0, 3'd0, 5'd0));
	put(2, alu_i(op_and, 3'd1, 3'd1, 5'd0));
	put(2, alu_i(op_add, 3'd1, 3'd1, 5'h1f)); // R1 = -1.
	put(2, br(3'b011, 9'd2)); // Not taken.
	put(2, mem(op_str, 3'd1, 3'd0, 6'd8));
	put(2, br(3'b100, 9'd3));
	put(2, mem(op_str, 3'd1, 3'd0, 6'd9));
	put(2, mem(op_str, 3'd1, 3'd0, 6'd10));
	put(2, mem(op_str, 3'd1, 3'd0, 6'd11));
	put(2, alu_i(op_add, 3'd5, 3'd0, 5'd1)); // Codes to p before the load.
	put(2, mem(op_ldr, 3'd2, 3'd0, 6'd8));
	put(2, br(3'b100, 9'd1));
	put(2, mem(op_str, 3'd1, 3'd0, 6'd12));
	put(2, alu_i(op_add, 3'd3, 3'd2, 5'd1));
	put(2, br(3'b010, 9'd1));
	put(2, mem(op_str, 3'd2, 3'd0, 6'd13));
	put(2, mem(op_str, 3'd3, 3'd0, 6'd14));
	put(2, br(3'b111, 9'h1ff));
	add_store(2, 16'h0010, 16'hffff);
	add_store(2, 16'h001c, 16'h0000);
endtask

task automatic check(input string name, input lc3b_word got, input lc3b_word exp);
	if (got !== exp) begin
		$display("mismatch %s: got %h, expected %h", name, got, exp);
		errors++;
	end
endtask

task automatic reset_dut();
	arst_n = 1'b0;
	repeat (5) begin
		@(posedge clk);
		#2;
		check("port cyc/stb/write", {11'b0, imem_cyc, imem_stb, dmem_cyc, dmem_stb, dmem_write},
			16'h0000);
	end
	st_addr_q.delete();
	st_data_q.delete();
	arst_n = 1'b1;
endtask

task automatic run_test(input int t);
	int err_before;
	int cycles;
	err_before = errors;
	for (int i = 0; i < 64; i++) begin
		imem[i] = (i < prog_len[t]) ? prog[t][i] : (16'hf000 | 16'(i)); // Unused opcode.
		dmem[i] = 16'h0040 + 16'(i);
	end
	reset_dut();
	cycles = 0;
	while (!imem_cyc && cycles < 10) begin
		@(posedge clk);
		#2;
		cycles++;
	end
	if (!imem_cyc) begin
		$display("test %0d: no instruction fetch after reset", t);
		errors++;
	end else begin
		check("imem_address", imem_address, `LC3B_RESET_PC);
	end
	cycles = 0;
	while (st_addr_q.size() < exp_cnt[t] && cycles < timeout_cycles) begin
		@(posedge clk);
		#2;
		cycles++;
	end
	if (st_addr_q.size() < exp_cnt[t]) begin
		$display("test %0d: program did not finish within %0d cycles", t, timeout_cycles);
		errors++;
	end else begin
		repeat (20) @(posedge clk); // Room for a stray store to show up.
		check("store count", 16'(st_addr_q.size()), 16'(exp_cnt[t]));
		for (int k = 0; k < exp_cnt[t]; k++) begin
			check("dmem_address", st_addr_q[k], exp_addr[t][k]);
			check("dmem_wdata", st_data_q[k], exp_data[t][k]);
		end
		#2;
	end
	if (errors == err_before) begin
		$display("test %0d: passed", t);
	end else begin
		$display("test %0d: failed", t);
		failed_tests++;
	end
endtask

initial begin
	arst_n = 1'b0;
	imem_rdata = '0;
	imem_resp = 1'b0;
	dmem_rdata = '0;
	dmem_resp = 1'b0;
	i_busy = 1'b0;
	d_busy = 1'b0;
	i_wait = 0;
	d_wait = 0;
	errors = 0;
	failed_tests = 0;
	build_tables();
	for (int t = 0; t < num_tests; t++) begin
		run_test(t);
	end
	$display("%0d tests run, %0d failed, %0d errors", num_tests, failed_tests, errors);
	if (errors == 0) begin
		$display("No errors");
	end else begin
		$display("Errors found");
	end
	$finish;
end

endmodule : tb_lc3b_pipeline
